//--- common/io_consts.svh
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// upper address nibble of each block
`define REGION_UART 4'h0
`define REGION_GPIO 4'h1
`define REGION_IRQ  4'h7
`define REGION_RAM  4'h8

// uart registers
`define UART_DATA   4'h0
`define UART_STATUS 4'h1

// gpio registers
`define GPIO_OUT  4'h0
`define GPIO_IN   4'h1
`define GPIO_MASK 4'h2
`define GPIO_FLAG 4'h3

// interrupt controller registers
`define IRQ_ENABLE  4'h0
`define IRQ_PENDING 4'h1

`define UART_FIFO_DEPTH 8

// clocks per serial bit, small so simulations stay short
`define UART_CLKS_PER_BIT 8

`define SCRATCH_WORDS 512

`endif

//--- common/io_pkg.sv
`default_nettype none

package io_pkg;

	// bus widths
	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0]  reg_off_t;	// register offset inside a block
	typedef logic [8:0]  ram_addr_t;
	typedef logic [7:0]  byte_t;	// uart character

	// interrupt sources: bit 0 gpio, bit 1 uart empty, bit 2 uart overflow
	typedef logic [2:0] irq_vec_t;
	typedef logic [1:0] irq_id_t;	// encoded source number

	// which block a bus cycle addressed
	typedef enum logic [2:0] {
		SEL_UART,
		SEL_GPIO,
		SEL_IRQ,
		SEL_RAM,
		SEL_NONE
	} periph_sel_t;

	// tx shifter states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} uart_state_t;

	// request as seen by every peripheral
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  wr;
		logic  rd;
	} bus_req_t;

endpackage

`default_nettype wire

//--- uart/uart_fifo.sv
`default_nettype none

`include "io_consts.svh"

module uart_fifo (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          push,
	input  io_pkg::byte_t push_data,
	input  logic          pop,
	output io_pkg::byte_t pop_data,
	output logic [3:0]    level,
	output logic          full,
	output logic          empty
);
	import io_pkg::*;

	localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

	byte_t            mem [`UART_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [3:0]       count_q;
	logic             push_ok;
	logic             pop_ok;

	assign full    = (count_q == 4'(`UART_FIFO_DEPTH));
	assign empty   = (count_q == 4'd0);
	assign push_ok = push && !full;	// uart flags the overflow
	assign pop_ok  = pop && !empty;

	always_ff @(posedge CLK) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];	// head of queue
	assign level    = count_q;

endmodule

`default_nettype wire

//--- uart/uart.sv
`default_nettype none

`include "io_consts.svh"

module uart (
	input  logic             CLK,
	input  logic             RSTb,
	input  io_pkg::bus_req_t req,
	input  logic             wr_sel,
	output io_pkg::word_t    rdata,
	output logic             uart_tx,
	output logic             tx_empty_int,
	output logic             overflow_int
);
	import io_pkg::*;

	localparam int BAUD_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_CLKS_PER_BIT - 1);

	reg_off_t    offset;
	logic        push;
	logic        pop;
	byte_t       pop_data;
	logic [3:0]  level;
	logic        full;
	logic        empty;
	logic        overflow_q;
	logic        ovf_clear;
	logic        busy;
	logic        baud_done;

	uart_state_t       state_q;
	logic [BAUD_W-1:0] baud_q;
	logic [2:0]        bit_q;	// data bit index
	byte_t             shift_q;

	assign offset    = req.addr[3:0];
	assign push      = wr_sel && (offset == `UART_DATA);
	assign ovf_clear = wr_sel && (offset == `UART_STATUS) && req.wdata[5];
	assign busy      = (state_q != ST_IDLE);
	assign baud_done = (baud_q == BAUD_LAST);
	assign pop       = !busy && !empty;	// load as soon as idle

	uart_fifo u_uart_fifo (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.push      (push),
		.push_data (req.wdata[7:0]),
		.pop       (pop),
		.pop_data  (pop_data),
		.level     (level),
		.full      (full),
		.empty     (empty)
	);

	// sticky, a write into a full fifo is dropped
	always_ff @(posedge CLK) begin
		if (!RSTb)
			overflow_q <= 1'b0;
		else if (push && full)
			overflow_q <= 1'b1;
		else if (ovf_clear)
			overflow_q <= 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q <= ST_IDLE;
			baud_q  <= '0;
			bit_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					baud_q <= '0;
					if (pop)
						state_q <= ST_START;
				end
				ST_START: begin
					baud_q <= baud_q + 1'b1;
					if (baud_done) begin
						state_q <= ST_DATA;
						bit_q   <= '0;
					end
				end
				ST_DATA: begin
					baud_q <= baud_q + 1'b1;
					if (baud_done) begin
						bit_q <= bit_q + 1'b1;
						if (bit_q == 3'd7)
							state_q <= ST_STOP;
					end
				end
				default: begin	// stop bit
					baud_q <= baud_q + 1'b1;
					if (baud_done)
						state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (pop)
			shift_q <= pop_data;
		else if (state_q == ST_DATA && baud_done)
			shift_q <= {1'b0, shift_q[7:1]};	// lsb first
	end

	always_comb begin
		case (state_q)
			ST_START: uart_tx = 1'b0;
			ST_DATA:  uart_tx = shift_q[0];
			default:  uart_tx = 1'b1;	// idle and stop
		endcase
	end

	always_comb begin
		rdata = '0;
		if (offset == `UART_STATUS)
			rdata = {10'd0, overflow_q, busy, level};
	end

	assign tx_empty_int = empty && !busy;
	assign overflow_int = overflow_q;

endmodule

`default_nettype wire

//--- logic/gpio.sv
`default_nettype none

`include "io_consts.svh"

module gpio (
	input  logic             CLK,
	input  logic             RSTb,
	input  io_pkg::bus_req_t req,
	input  logic             wr_sel,
	input  logic             rd_sel,
	output io_pkg::word_t    rdata,
	input  logic [5:0]       gpio_in,
	output logic [3:0]       gpio_out,
	output logic             gpio_int
);
	import io_pkg::*;

	reg_off_t   offset;
	logic [3:0] out_q;
	logic [5:0] sync1_q;
	logic [5:0] sync2_q;
	logic [5:0] prev_q;	// last synchronized value for edge detect
	logic [5:0] mask_q;
	logic [5:0] flag_q;
	logic [5:0] rise;
	logic       flag_clear;

	assign offset     = req.addr[3:0];
	assign rise       = sync2_q & ~prev_q & mask_q;
	assign flag_clear = rd_sel && (offset == `GPIO_FLAG);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			out_q   <= '0;
			mask_q  <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			flag_q  <= '0;
		end else begin
			sync1_q <= gpio_in;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			if (wr_sel && offset == `GPIO_OUT)
				out_q <= req.wdata[3:0];
			if (wr_sel && offset == `GPIO_MASK)
				mask_q <= req.wdata[5:0];
			// an edge in the same cycle as the clearing read survives
			if (flag_clear)
				flag_q <= rise;
			else
				flag_q <= flag_q | rise;
		end
	end

	always_comb begin
		case (offset)
			`GPIO_OUT:  rdata = {12'd0, out_q};
			`GPIO_IN:   rdata = {10'd0, sync2_q};
			`GPIO_MASK: rdata = {10'd0, mask_q};
			`GPIO_FLAG: rdata = {10'd0, flag_q};
			default:    rdata = '0;
		endcase
	end

	assign gpio_out = out_q;
	assign gpio_int = |flag_q;

endmodule

`default_nettype wire

//--- logic/interrupt_controller.sv
`default_nettype none

`include "io_consts.svh"

module interrupt_controller (
	input  logic             CLK,
	input  logic             RSTb,
	input  io_pkg::bus_req_t req,
	input  logic             wr_sel,
	output io_pkg::word_t    rdata,
	input  io_pkg::irq_vec_t sources,
	output io_pkg::irq_id_t  irq,
	output logic             interrupt
);
	import io_pkg::*;

	reg_off_t offset;
	irq_vec_t enable_q;
	irq_vec_t pending_q;
	irq_vec_t clear;
	irq_vec_t active;

	assign offset = req.addr[3:0];

	// write one to clear
	assign clear = (wr_sel && offset == `IRQ_PENDING) ? req.wdata[2:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable_q  <= '0;
			pending_q <= '0;
		end else begin
			if (wr_sel && offset == `IRQ_ENABLE)
				enable_q <= req.wdata[2:0];
			// a source still high sets the bit again
			pending_q <= (pending_q & ~clear) | sources;
		end
	end

	assign active    = pending_q & enable_q;
	assign interrupt = |active;

	// lowest number wins
	always_comb begin
		if (active[0])
			irq = 2'd0;
		else if (active[1])
			irq = 2'd1;
		else if (active[2])
			irq = 2'd2;
		else
			irq = 2'd0;
	end

	always_comb begin
		case (offset)
			`IRQ_ENABLE:  rdata = {13'd0, enable_q};
			`IRQ_PENDING: rdata = {13'd0, pending_q};
			default:      rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/scratch_ram.sv
`default_nettype none

`include "io_consts.svh"

module scratch_ram (
	input  logic              CLK,
	input  io_pkg::ram_addr_t addr,
	input  io_pkg::word_t     wdata,
	input  logic              we,
	output io_pkg::word_t     rdata
);
	import io_pkg::*;

	word_t mem [`SCRATCH_WORDS];

	// read before write on the same address
	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];	// registered read port
	end

endmodule

`default_nettype wire

//--- port_controller/port_controller.sv
`default_nettype none

`include "io_consts.svh"

module port_controller (
	input  logic              CLK,
	input  logic              RSTb,
	input  io_pkg::addr_t     ADDRESS,
	input  io_pkg::word_t     DATA_IN,
	input  logic              memWR,
	input  logic              memRD,
	output io_pkg::word_t     DATA_OUT,
	input  logic [5:0]        gpio_in,
	output logic [3:0]        gpio_out,
	output logic              uart_tx,
	output io_pkg::irq_id_t   irq,
	output logic              interrupt
);
	import io_pkg::*;

	bus_req_t    req;
	periph_sel_t sel;
	periph_sel_t sel_q;	// block addressed in the previous cycle

	logic wr_uart;
	logic wr_gpio;
	logic wr_irq;
	logic wr_ram;
	logic rd_gpio;

	word_t uart_rdata;
	word_t gpio_rdata;
	word_t irq_rdata;
	word_t ram_rdata;
	word_t rdata_mux;
	word_t rdata_q;

	logic     gpio_int;
	logic     tx_empty_int;
	logic     overflow_int;
	irq_vec_t sources;

	assign req = '{addr: ADDRESS, wdata: DATA_IN, wr: memWR, rd: memRD};

	// region decode on the top nibble
	always_comb begin
		sel = SEL_NONE;
		case (ADDRESS[15:12])
			`REGION_UART: sel = SEL_UART;
			`REGION_GPIO: sel = SEL_GPIO;
			`REGION_IRQ:  sel = SEL_IRQ;
			`REGION_RAM: begin
				// only the bottom of the region is backed by RAM
				if (ADDRESS[11:0] < 12'(`SCRATCH_WORDS))
					sel = SEL_RAM;
			end
			default: sel = SEL_NONE;
		endcase
	end

	assign wr_uart = memWR && (sel == SEL_UART);
	assign wr_gpio = memWR && (sel == SEL_GPIO);
	assign wr_irq  = memWR && (sel == SEL_IRQ);
	assign wr_ram  = memWR && (sel == SEL_RAM);
	assign rd_gpio = memRD && (sel == SEL_GPIO);	// flag read clears

	always_comb begin
		case (sel)
			SEL_UART: rdata_mux = uart_rdata;
			SEL_GPIO: rdata_mux = gpio_rdata;
			SEL_IRQ:  rdata_mux = irq_rdata;
			default:  rdata_mux = '0;	// ram has its own register, unmapped reads 0
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sel_q   <= SEL_NONE;
			rdata_q <= '0;
		end else begin
			sel_q   <= sel;
			rdata_q <= rdata_mux;
		end
	end

	// ram output is already one cycle late
	assign DATA_OUT = (sel_q == SEL_RAM) ? ram_rdata : rdata_q;

	assign sources = {overflow_int, tx_empty_int, gpio_int};

	uart u_uart (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.req          (req),
		.wr_sel       (wr_uart),
		.rdata        (uart_rdata),
		.uart_tx      (uart_tx),
		.tx_empty_int (tx_empty_int),
		.overflow_int (overflow_int)
	);

	gpio u_gpio (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.req      (req),
		.wr_sel   (wr_gpio),
		.rd_sel   (rd_gpio),
		.rdata    (gpio_rdata),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_int (gpio_int)
	);

	interrupt_controller u_interrupt_controller (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.req       (req),
		.wr_sel    (wr_irq),
		.rdata     (irq_rdata),
		.sources   (sources),
		.irq       (irq),
		.interrupt (interrupt)
	);

	scratch_ram u_scratch_ram (
		.CLK   (CLK),
		.addr  (ADDRESS[8:0]),
		.wdata (DATA_IN),
		.we    (wr_ram),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

//--- tb/io_model.sv
`default_nettype none

`include "io_consts.svh"

module io_model;
	timeunit 1ns;
	timeprecision 100ps;
	import io_pkg::*;

	word_t      ram_m [`SCRATCH_WORDS];
	bit         ram_valid [`SCRATCH_WORDS];
	byte_t      uart_exp [$];	// bytes expected on the serial line
	bit         uart_ovf = 1'b0;
	logic [3:0] gpio_out_m = '0;
	logic [5:0] gpio_mask_m = '0;
	logic [5:0] gpio_prev_m = '0;
	logic [5:0] gpio_flag_m = '0;
	irq_vec_t   irq_en_m = '0;
	irq_vec_t   irq_pend_m = '0;

	function automatic void ram_store(ram_addr_t a, word_t d);
		ram_m[a] = d;
		ram_valid[a] = 1'b1;
	endfunction

	function automatic word_t ram_fetch(ram_addr_t a);
		return ram_m[a];
	endfunction

	// burst into an idle uart, the first byte goes straight to the shifter
	function automatic void uart_accept(int idx, byte_t v);
		if (idx <= `UART_FIFO_DEPTH)
			uart_exp.push_back(v);
		else
			uart_ovf = 1'b1;
	endfunction

	function automatic int uart_left();
		return uart_exp.size();
	endfunction

	function automatic byte_t uart_next();
		return uart_exp.pop_front();
	endfunction

	function automatic void uart_flush();
		uart_exp.delete();
	endfunction

	function automatic void gpio_pins(logic [5:0] v);
		gpio_flag_m = gpio_flag_m | (v & ~gpio_prev_m & gpio_mask_m);
		gpio_prev_m = v;
	endfunction

	function automatic logic [5:0] gpio_take_flag();
		logic [5:0] f;
		f = gpio_flag_m;
		gpio_flag_m = '0;	// read clears
		return f;
	endfunction

	function automatic void irq_observe(irq_vec_t src);
		irq_pend_m = irq_pend_m | src;
	endfunction

	function automatic void irq_clear(irq_vec_t c, irq_vec_t src);
		irq_pend_m = (irq_pend_m & ~c) | src;	// live sources stay pending
	endfunction

	function automatic logic irq_active();
		return |(irq_pend_m & irq_en_m);
	endfunction

	function automatic irq_id_t irq_expected_id();
		irq_vec_t act;
		act = irq_pend_m & irq_en_m;
		if (act[0])
			return 2'd0;
		if (act[1])
			return 2'd1;
		if (act[2])
			return 2'd2;
		return 2'd0;
	endfunction

endmodule

`default_nettype wire

//--- tb/tb_port_controller.sv
`default_nettype none

`include "io_consts.svh"

module tb_port_controller;
	timeunit 1ns;
	timeprecision 100ps;
	import io_pkg::*;

	localparam int RAM_OPS = 200;
	localparam int UNMAPPED_OPS = 40;
	localparam int UART_BURSTS = 6;
	localparam int GPIO_OPS = 40;
	localparam int IRQ_OPS = 12;
	localparam int BURST_DRAIN = (`UART_FIFO_DEPTH + 1) * 10 * `UART_CLKS_PER_BIT;
	localparam int BUS_OPS = RAM_OPS + UNMAPPED_OPS + UART_BURSTS * 16 + GPIO_OPS * 4
		+ IRQ_OPS * 16;
	localparam int WATCHDOG_CYCLES = BUS_OPS * 4 + GPIO_OPS * 10 + IRQ_OPS * 20
		+ (UART_BURSTS + IRQ_OPS + 2) * BURST_DRAIN + 2000;

	localparam addr_t UART_DATA_ADDR = {`REGION_UART, 8'h00, `UART_DATA};
	localparam addr_t UART_STAT_ADDR = {`REGION_UART, 8'h00, `UART_STATUS};
	localparam addr_t GPIO_OUT_ADDR  = {`REGION_GPIO, 8'h00, `GPIO_OUT};
	localparam addr_t GPIO_MASK_ADDR = {`REGION_GPIO, 8'h00, `GPIO_MASK};
	localparam addr_t GPIO_FLAG_ADDR = {`REGION_GPIO, 8'h00, `GPIO_FLAG};
	localparam addr_t IRQ_EN_ADDR    = {`REGION_IRQ, 8'h00, `IRQ_ENABLE};
	localparam addr_t IRQ_PEND_ADDR  = {`REGION_IRQ, 8'h00, `IRQ_PENDING};

	logic       CLK;
	logic       RSTb;
	addr_t      ADDRESS;
	word_t      DATA_IN;
	word_t      DATA_OUT;
	logic       memWR;
	logic       memRD;
	logic [5:0] gpio_in;
	logic [3:0] gpio_out;
	logic       uart_tx;
	irq_id_t    irq;
	logic       interrupt;

	int    errors = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	byte_t rx_q [$];	// bytes rebuilt from uart_tx

	port_controller u_port_controller (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.ADDRESS   (ADDRESS),
		.DATA_IN   (DATA_IN),
		.memWR     (memWR),
		.memRD     (memRD),
		.DATA_OUT  (DATA_OUT),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out),
		.uart_tx   (uart_tx),
		.irq       (irq),
		.interrupt (interrupt)
	);

	io_model u_model ();

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_CYCLES * 4);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	// samples each serial bit in its middle
	initial begin : uart_monitor
		byte_t b;
		forever begin
			@(negedge CLK);
			if (RSTb && uart_tx == 1'b0) begin
				repeat (`UART_CLKS_PER_BIT / 2) @(negedge CLK);
				if (uart_tx !== 1'b0) begin
					$display("uart start bit was too short");
					errors++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (`UART_CLKS_PER_BIT) @(negedge CLK);
					b[i] = uart_tx;
				end
				repeat (`UART_CLKS_PER_BIT) @(negedge CLK);
				if (uart_tx !== 1'b1) begin
					$display("uart stop bit missing");
					errors++;
				end
				rx_q.push_back(b);
			end
		end
	end

	task automatic report_mismatch(string name, logic [15:0] expv, logic [15:0] act);
		$display("CHECK FAILED %s expected %h actual %h", name, expv, act);
		errors++;
	endtask

	task automatic finish_test(string name, int start_errors);
		if (errors == start_errors) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic idle(int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic bus_write(addr_t a, word_t d);
		ADDRESS = a;
		DATA_IN = d;
		memWR = 1'b1;
		@(posedge CLK);
		#1;
		memWR = 1'b0;
	endtask

	task automatic bus_read(addr_t a, output word_t d);
		ADDRESS = a;
		memRD = 1'b1;
		@(posedge CLK);
		#1;
		memRD = 1'b0;
		d = DATA_OUT;	// one cycle latency
	endtask

	task automatic wait_uart_idle();
		word_t st;
		st = 16'hffff;
		while (st[4:0] != 5'd0)
			bus_read(UART_STAT_ADDR, st);
		idle(2);
	endtask

	task automatic compare_uart();
		byte_t e;
		byte_t r;
		while (u_model.uart_left() > 0 && rx_q.size() > 0) begin
			e = u_model.uart_next();
			r = rx_q.pop_front();
			if (r !== e)
				report_mismatch("uart_tx byte", {8'h00, e}, {8'h00, r});
		end
		if (u_model.uart_left() != rx_q.size()) begin
			$display("uart byte count wrong: %0d expected bytes missing, %0d extra bytes sent",
				u_model.uart_left(), rx_q.size());
			errors++;
			u_model.uart_flush();
			rx_q.delete();
		end
	endtask

	task automatic uart_burst(int n);
		byte_t v;
		for (int k = 0; k < n; k++) begin
			v = byte_t'($urandom);
			bus_write(UART_DATA_ADDR, {8'h00, v});
			u_model.uart_accept(k, v);
		end
	endtask

	task automatic irq_sources_check();
		word_t rd;
		if (interrupt !== u_model.irq_active())
			report_mismatch("interrupt", {15'd0, u_model.irq_active()}, {15'd0, interrupt});
		if (u_model.irq_active() && irq !== u_model.irq_expected_id())
			report_mismatch("irq", {14'd0, u_model.irq_expected_id()}, {14'd0, irq});
		bus_read(IRQ_PEND_ADDR, rd);
		if (rd !== {13'd0, u_model.irq_pend_m})
			report_mismatch("DATA_OUT pending", {13'd0, u_model.irq_pend_m}, rd);
		bus_read(IRQ_EN_ADDR, rd);
		if (rd !== {13'd0, u_model.irq_en_m})
			report_mismatch("DATA_OUT enable", {13'd0, u_model.irq_en_m}, rd);
	endtask

	initial begin : main
		int          start;
		int          n;
		int unsigned a;
		word_t       d;
		word_t       rd;
		logic [5:0]  pins;
		irq_vec_t    c;

		void'($urandom(32'hb991_7962));
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		memWR = 1'b0;
		memRD = 1'b0;
		gpio_in = '0;
		repeat (8) @(posedge CLK);
		#1;
		RSTb = 1'b1;

		start = errors;
		if (uart_tx !== 1'b1)
			report_mismatch("uart_tx", 16'h1, {15'd0, uart_tx});
		if (gpio_out !== 4'h0)
			report_mismatch("gpio_out", 16'h0, {12'd0, gpio_out});
		if (interrupt !== 1'b0)
			report_mismatch("interrupt", 16'h0, {15'd0, interrupt});
		if (DATA_OUT !== 16'h0)
			report_mismatch("DATA_OUT", 16'h0, DATA_OUT);
		finish_test("reset", start);

		start = errors;
		for (int i = 0; i < RAM_OPS; i++) begin
			a = $urandom_range(`SCRATCH_WORDS - 1);
			if ($urandom_range(1) == 0 || !u_model.ram_valid[a]) begin
				d = word_t'($urandom);
				bus_write(addr_t'(32'h8000 + a), d);
				u_model.ram_store(ram_addr_t'(a), d);
			end else begin
				bus_read(addr_t'(32'h8000 + a), rd);
				if (rd !== u_model.ram_fetch(ram_addr_t'(a)))
					report_mismatch("DATA_OUT ram", u_model.ram_fetch(ram_addr_t'(a)), rd);
			end
		end
		for (int i = 0; i < UNMAPPED_OPS; i++) begin
			bus_read(addr_t'($urandom_range(32'h6fff, 32'h2000)), rd);
			if (rd !== 16'h0)
				report_mismatch("DATA_OUT unmapped", 16'h0, rd);
		end
		finish_test("scratch ram", start);

		start = errors;
		for (int b = 0; b < UART_BURSTS; b++) begin
			wait_uart_idle();
			if (b == 0)
				n = `UART_FIFO_DEPTH + 3;	// first burst always overflows
			else
				n = int'($urandom_range(12, 1));
			uart_burst(n);
			bus_read(UART_STAT_ADDR, rd);
			if (rd[5] !== u_model.uart_ovf)
				report_mismatch("DATA_OUT overflow", {15'd0, u_model.uart_ovf}, {15'd0, rd[5]});
			if (u_model.uart_ovf) begin
				bus_write(UART_STAT_ADDR, 16'h0020);
				u_model.uart_ovf = 1'b0;
				bus_read(UART_STAT_ADDR, rd);
				if (rd[5] !== 1'b0)
					report_mismatch("DATA_OUT overflow clear", 16'h0, {15'd0, rd[5]});
			end
		end
		wait_uart_idle();
		compare_uart();
		finish_test("uart", start);

		start = errors;
		for (int i = 0; i < GPIO_OPS / 2; i++) begin
			d = word_t'($urandom);
			bus_write(GPIO_OUT_ADDR, d);
			u_model.gpio_out_m = d[3:0];
			bus_read(GPIO_OUT_ADDR, rd);
			if (rd !== {12'd0, u_model.gpio_out_m})
				report_mismatch("DATA_OUT gpio out", {12'd0, u_model.gpio_out_m}, rd);
			if (gpio_out !== u_model.gpio_out_m)
				report_mismatch("gpio_out", {12'd0, u_model.gpio_out_m}, {12'd0, gpio_out});
		end
		for (int i = 0; i < GPIO_OPS / 2; i++) begin
			d = word_t'($urandom_range(63));
			bus_write(GPIO_MASK_ADDR, d);
			u_model.gpio_mask_m = d[5:0];
			pins = 6'($urandom_range(63));
			gpio_in = pins;
			u_model.gpio_pins(pins);
			idle(4);	// two sync flops plus the flag edge
			if ($urandom_range(1) == 1 || i == GPIO_OPS / 2 - 1) begin
				bus_read(GPIO_FLAG_ADDR, rd);
				d = {10'd0, u_model.gpio_take_flag()};
				if (rd !== d)
					report_mismatch("DATA_OUT gpio flag", d, rd);
			end
		end
		finish_test("gpio", start);

		start = errors;
		bus_write(IRQ_PEND_ADDR, 16'h0007);
		u_model.irq_clear(3'b111, {u_model.uart_ovf, 1'b1, |u_model.gpio_flag_m});
		for (int i = 0; i < IRQ_OPS; i++) begin
			c = irq_vec_t'($urandom_range(7));
			bus_write(IRQ_EN_ADDR, {13'd0, c});
			u_model.irq_en_m = c;
			if ($urandom_range(1) == 1) begin
				bus_write(GPIO_MASK_ADDR, 16'h003f);
				u_model.gpio_mask_m = 6'h3f;
				gpio_in = '0;
				u_model.gpio_pins(6'h00);
				idle(4);
				pins = 6'(1 << $urandom_range(5));
				gpio_in = pins;
				u_model.gpio_pins(pins);
				idle(5);
			end else begin
				bus_read(GPIO_FLAG_ADDR, rd);
				d = {10'd0, u_model.gpio_take_flag()};
				if (rd !== d)
					report_mismatch("DATA_OUT gpio flag", d, rd);
				idle(1);
			end
			u_model.irq_observe({u_model.uart_ovf, 1'b1, |u_model.gpio_flag_m});
			if ($urandom_range(3) == 0) begin
				uart_burst(`UART_FIFO_DEPTH + 2);	// one too many
				wait_uart_idle();
			end else if (u_model.uart_ovf && $urandom_range(1) == 1) begin
				bus_write(UART_STAT_ADDR, 16'h0020);
				u_model.uart_ovf = 1'b0;
				idle(1);
			end
			u_model.irq_observe({u_model.uart_ovf, 1'b1, |u_model.gpio_flag_m});
			c = irq_vec_t'($urandom_range(7));
			bus_write(IRQ_PEND_ADDR, {13'd0, c});
			u_model.irq_clear(c, {u_model.uart_ovf, 1'b1, |u_model.gpio_flag_m});
			irq_sources_check();
		end
		wait_uart_idle();
		compare_uart();
		finish_test("interrupts", start);

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/io_pkg.sv
uart/uart_fifo.sv
uart/uart.sv
logic/gpio.sv
logic/interrupt_controller.sv
logic/scratch_ram.sv
port_controller/port_controller.sv
tb/io_model.sv
tb/tb_port_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the port controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f vlog.f \
	--top-module tb_port_controller \
	-Mdir obj_dir

./obj_dir/Vtb_port_controller | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0
